//--- hw/load_pkg.sv
// shared widths of the load unit
// load operator encoding
// packed structs for the issue port, exceptions, cache port and captured load

package load_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    // integer register and cache data width
    localparam int unsigned XLEN = 64;
    // Sv39 virtual address
    localparam int unsigned VLEN = 39;
    // physical address as produced by the TLB
    localparam int unsigned PLEN = 56;
    // scoreboard tag that travels with each load
    localparam int unsigned TRANS_ID_BITS = 3;
    // the cache index lies fully inside the page offset, so it needs no translation
    localparam int unsigned INDEX_WIDTH = 12;
    // tag bits sit directly above the index in the physical address
    localparam int unsigned TAG_WIDTH = 44;
    // 4 KiB pages
    localparam int unsigned PAGE_OFFSET_BITS = 12;

    // ------------------------------------------------------------------------
    // load operators
    // ------------------------------------------------------------------------
    // the U variants zero extend, the others sign extend except LD
    typedef enum logic [2:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU
    } ld_op_e;

    // ------------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------------
    // one load request as offered by the issue stage
    typedef struct packed {
        logic [VLEN-1:0]          vaddr;
        logic [TRANS_ID_BITS-1:0] trans_id;
        ld_op_e                   op;
        logic [7:0]               be;
    } load_req_t;

    // exception raised by translation or by the misalignment check
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    // request channel towards the data cache, read only
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] address_index;
        logic [TAG_WIDTH-1:0]   address_tag;
        logic                   data_req;
        logic                   kill_req;
        logic                   tag_valid;
        logic [7:0]             data_be;
        logic [1:0]             data_size;
    } dcache_req_t;

    // response channel from the data cache
    typedef struct packed {
        logic            data_gnt;
        logic            data_rvalid;
        logic [XLEN-1:0] data_rdata;
    } dcache_rsp_t;

    // what has to be remembered of a load between grant and data return
    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [2:0]               offset;
        ld_op_e                   op;
    } load_entry_t;

endpackage

//--- hw/load_fsm.sv
// load control FSM of the load unit
// page offset match register, captured load entry and retire logic

module load_fsm (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    // issue side
    input  logic                              valid_i,
    input  load_pkg::load_req_t               load_req_i,
    input  logic                              ex_valid_i,
    output logic                              pop_ld_o,
    // translation and address check
    output logic                              translation_req_o,
    input  logic                              dtlb_hit_i,
    input  logic                              page_offset_matches_i,
    // cache handshake
    output logic                              data_req_o,
    output logic                              kill_req_o,
    output logic                              tag_valid_o,
    output logic [1:0]                        data_size_o,
    input  logic                              data_gnt_i,
    input  logic                              data_rvalid_i,
    // retire side
    output logic                              valid_o,
    output logic [load_pkg::TRANS_ID_BITS-1:0] trans_id_o,
    // captured entry for the result formatter
    output load_pkg::load_entry_t             ld_next_o,
    output load_pkg::load_entry_t             ld_q_o
);
    import load_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_e;

    state_e      state_d, state_q;
    load_entry_t load_data_d, load_data_q;
    load_entry_t in_data;
    logic        page_offset_matches_q;
    logic        accept_new;

    // the entry that would be captured if the current request is popped
    assign in_data = '{
        trans_id: load_req_i.trans_id,
        offset:   load_req_i.vaddr[2:0],
        op:       load_req_i.op
    };

    // a new request may start from idle and also in the tag cycle of the previous load
    assign accept_new = (state_q == IDLE) || (state_q == SEND_TAG);

    // ------------------------------------------------------------------------
    // load control
    // ------------------------------------------------------------------------
    always_comb begin : load_control
        state_d           = state_q;
        load_data_d       = load_data_q;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        kill_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        pop_ld_o          = 1'b0;

        case (state_q)
            // the translation result of the granted request arrives as tag now
            SEND_TAG: begin
                tag_valid_o = 1'b1;
                state_d     = IDLE;
                // an excepting request in this cycle also throws away the tag
                if (ex_valid_i) begin
                    kill_req_o = 1'b1;
                end
            end
            // a store to the same page offset is pending, so hold off the cache
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_q) begin
                    state_d = WAIT_GNT;
                end
            end
            // TLB miss: release the cache arbiter so the page table walker can use it
            ABORT_TRANSACTION: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // keep both the translation and the cache request up until granted
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
                if (data_gnt_i) begin
                    if (dtlb_hit_i) begin
                        state_d  = SEND_TAG;
                        pop_ld_o = 1'b1;
                    end else begin
                        state_d = ABORT_TRANSACTION;
                    end
                end
            end
            // the cache only forwards the kill if a request is outstanding
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end
            default: begin
                state_d = state_q;
            end
        endcase

        // start a request, translation runs in parallel to the page offset check
        if (accept_new && valid_i) begin
            translation_req_o = 1'b1;
            if (page_offset_matches_q) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                // the index goes out right away
                data_req_o = 1'b1;
                if (!data_gnt_i) begin
                    state_d = WAIT_GNT;
                end else if (dtlb_hit_i) begin
                    state_d  = SEND_TAG;
                    pop_ld_o = 1'b1;
                end else begin
                    state_d = ABORT_TRANSACTION;
                end
            end
        end

        // an excepting load never reaches the cache
        if (ex_valid_i && valid_i) begin
            state_d = IDLE;
            // an rvalid this cycle belongs to the older load, so the exception waits a round
            if (!data_rvalid_i) begin
                pop_ld_o = 1'b1;
            end
        end

        // only loads that will return data are remembered
        if (pop_ld_o && !ex_valid_i) begin
            load_data_d = in_data;
        end

        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // transfer size follows the operator of the request on the issue port
    always_comb begin : size_decode
        case (load_req_i.op)
            LD:       data_size_o = 2'b11;
            LW, LWU:  data_size_o = 2'b10;
            LH, LHU:  data_size_o = 2'b01;
            default:  data_size_o = 2'b00;
        endcase
    end

    // ------------------------------------------------------------------------
    // retire
    // ------------------------------------------------------------------------
    always_comb begin : retire
        valid_o    = 1'b0;
        trans_id_o = load_data_q.trans_id;
        // data returns in the tag cycle, except when flushing or killed
        if (data_rvalid_i && (state_q != WAIT_FLUSH) && !kill_req_o) begin
            valid_o = 1'b1;
        end
        // exceptions retire early with the tag of the request on the issue port
        if (valid_i && ex_valid_i && !data_rvalid_i) begin
            valid_o    = 1'b1;
            trans_id_o = load_req_i.trans_id;
        end
    end

    assign ld_next_o = load_data_d;
    assign ld_q_o    = load_data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_regs
        if (!rst_ni) begin
            state_q               <= IDLE;
            page_offset_matches_q <= 1'b0;
        end else begin
            state_q               <= state_d;
            page_offset_matches_q <= page_offset_matches_i;
        end
    end

    always_ff @(posedge clk_i) begin : entry_reg
        load_data_q <= load_data_d;
    end

    // a pop needs either a grant in the same cycle or an early exception
    pop_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_ld_o |-> (data_gnt_i || ex_valid_i));

    // outside abort and flush the tag is only sent in the cycle after a pop
    tag_after_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (tag_valid_o && !(state_q inside {ABORT_TRANSACTION, WAIT_FLUSH}))
        |-> $past(pop_ld_o));

endmodule

//--- hw/load_result_align.sv
// result formatter of the load unit
// read data realignment, registered sign bit preselection and result mux

module load_result_align (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // retire strobe of the load FSM
    input  logic                       valid_i,
    input  logic [load_pkg::XLEN-1:0]  data_rdata_i,
    // entry to be captured and entry already captured
    input  load_pkg::load_entry_t      ld_next_i,
    input  load_pkg::load_entry_t      ld_q_i,
    output logic [load_pkg::XLEN-1:0]  result_o
);
    import load_pkg::*;

    logic [XLEN-1:0] shifted_data;
    logic [7:0]      sign_bits;
    logic [2:0]      idx_d, idx_q;
    logic            signed_d, signed_q;
    logic            sign_bit;

    // the captured byte offset moves the addressed data down to bit 0
    assign shifted_data = data_rdata_i >> {ld_q_i.offset, 3'b000};

    // ------------------------------------------------------------------------
    // sign preselection
    // ------------------------------------------------------------------------
    // decoded one cycle ahead from the next entry, so data return only sees a mux
    assign signed_d = ld_next_i.op inside {LW, LH, LB};

    // index of the byte that holds the sign bit of the loaded value
    always_comb begin : sign_idx
        case (ld_next_i.op)
            LW:      idx_d = ld_next_i.offset + 3'd3;
            LH:      idx_d = ld_next_i.offset + 3'd1;
            default: idx_d = ld_next_i.offset;
        endcase
    end

    // top bit of each byte lane of the unshifted data
    assign sign_bits = {
        data_rdata_i[63], data_rdata_i[55], data_rdata_i[47], data_rdata_i[39],
        data_rdata_i[31], data_rdata_i[23], data_rdata_i[15], data_rdata_i[7]
    };

    // unsigned loads pull the extension to zero
    assign sign_bit = signed_q & sign_bits[idx_q];

    // ------------------------------------------------------------------------
    // result mux
    // ------------------------------------------------------------------------
    always_comb begin : result_mux
        case (ld_q_i.op)
            LW, LWU: result_o = {{(XLEN - 32){sign_bit}}, shifted_data[31:0]};
            LH, LHU: result_o = {{(XLEN - 16){sign_bit}}, shifted_data[15:0]};
            LB, LBU: result_o = {{(XLEN - 8){sign_bit}}, shifted_data[7:0]};
            default: result_o = shifted_data;
        endcase
    end

    // same edge as the captured entry in the FSM
    always_ff @(posedge clk_i or negedge rst_ni) begin : sign_regs
        if (!rst_ni) begin
            idx_q    <= 3'd0;
            signed_q <= 1'b0;
        end else begin
            idx_q    <= idx_d;
            signed_q <= signed_d;
        end
    end

    // misaligned accesses should have been trapped before issue
    word_offset: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i && (ld_q_i.op inside {LW, LWU})) |-> (ld_q_i.offset < 3'd5));
    half_offset: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i && (ld_q_i.op inside {LH, LHU})) |-> (ld_q_i.offset < 3'd7));
    double_offset: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i && (ld_q_i.op == LD)) |-> (ld_q_i.offset == 3'd0));

endmodule

//--- hw/load_unit.sv
// top level of the load unit
// joins the load FSM and the result formatter, builds the cache request

module load_unit (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   flush_i,
    // issue side
    input  logic                                   valid_i,
    input  load_pkg::load_req_t                    load_req_i,
    output logic                                   pop_ld_o,
    // retire side
    output logic                                   valid_o,
    output logic [load_pkg::TRANS_ID_BITS-1:0]     trans_id_o,
    output logic [load_pkg::XLEN-1:0]              result_o,
    output load_pkg::exception_t                   ex_o,
    // address translation
    output logic                                   translation_req_o,
    output logic [load_pkg::VLEN-1:0]              vaddr_o,
    input  logic [load_pkg::PLEN-1:0]              paddr_i,
    input  load_pkg::exception_t                   ex_i,
    input  logic                                   dtlb_hit_i,
    // store address check
    output logic [load_pkg::PAGE_OFFSET_BITS-1:0]  page_offset_o,
    input  logic                                   page_offset_matches_i,
    // data cache
    output load_pkg::dcache_req_t                  dcache_req_o,
    input  load_pkg::dcache_rsp_t                  dcache_rsp_i
);
    import load_pkg::*;

    load_entry_t ld_next, ld_q;

    // the address checker and the TLB both see the untranslated address
    assign vaddr_o       = load_req_i.vaddr;
    assign page_offset_o = load_req_i.vaddr[PAGE_OFFSET_BITS-1:0];
    // translation and misalignment faults go straight to the scoreboard
    assign ex_o          = ex_i;

    // index from the virtual address, tag from this cycle's translation
    assign dcache_req_o.address_index = load_req_i.vaddr[INDEX_WIDTH-1:0];
    assign dcache_req_o.address_tag   = paddr_i[TAG_WIDTH+INDEX_WIDTH-1:INDEX_WIDTH];
    assign dcache_req_o.data_be       = load_req_i.be;

    load_fsm i_load_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .load_req_i            (load_req_i),
        .ex_valid_i            (ex_i.valid),
        .pop_ld_o              (pop_ld_o),
        .translation_req_o     (translation_req_o),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_matches_i (page_offset_matches_i),
        .data_req_o            (dcache_req_o.data_req),
        .kill_req_o            (dcache_req_o.kill_req),
        .tag_valid_o           (dcache_req_o.tag_valid),
        .data_size_o           (dcache_req_o.data_size),
        .data_gnt_i            (dcache_rsp_i.data_gnt),
        .data_rvalid_i         (dcache_rsp_i.data_rvalid),
        .valid_o               (valid_o),
        .trans_id_o            (trans_id_o),
        .ld_next_o             (ld_next),
        .ld_q_o                (ld_q)
    );

    // formats the returning data of the captured load
    load_result_align i_load_result_align (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .valid_i      (valid_o),
        .data_rdata_i (dcache_rsp_i.data_rdata),
        .ld_next_i    (ld_next),
        .ld_q_i       (ld_q),
        .result_o     (result_o)
    );

endmodule

//--- tb/tb_clkgen.sv
// clock and reset generator of the load unit testbench
// 4 ns clock, active low reset held for three cycles

module tb_clkgen (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset goes away shortly after the last reset edge, like any other driven input
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

//--- tb/tb_dcache_model.sv
// TLB and data cache responder of the load unit testbench
// random grant delay, identity translation, data pattern per doubleword

module tb_dcache_model (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // holds the TLB in a miss while high
    input  logic                      tlb_block_i,
    input  logic                      translation_req_i,
    input  logic [load_pkg::VLEN-1:0] vaddr_i,
    output logic                      dtlb_hit_o,
    output logic [load_pkg::PLEN-1:0] paddr_o,
    input  load_pkg::dcache_req_t     dcache_req_i,
    output load_pkg::dcache_rsp_t     dcache_rsp_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import load_pkg::*;

    integer          seed;
    logic [1:0]      delay_q;
    logic [1:0]      wait_q;
    logic [VLEN-1:0] addr_q;

    // every bit of the doubleword address above the byte offset shapes the data
    function automatic logic [XLEN-1:0] dword_pattern(input logic [VLEN-1:0] addr);
        return {addr[VLEN-1:3], addr[VLEN-1:11]} ^ 64'h9e37_79b9_7f4a_7c15;
    endfunction

    initial seed = 4;

    // translation answers in the same cycle with paddr equal to vaddr
    assign dtlb_hit_o = translation_req_i && !tlb_block_i;
    assign paddr_o    = {{(PLEN - VLEN){1'b0}}, vaddr_i};

    // a request is granted once it has waited for the drawn number of cycles
    assign dcache_rsp_o.data_gnt = dcache_req_i.data_req && (wait_q >= delay_q);

    // data comes back in the tag cycle unless the request is killed
    assign dcache_rsp_o.data_rvalid = dcache_req_i.tag_valid && !dcache_req_i.kill_req;
    assign dcache_rsp_o.data_rdata  = dword_pattern(addr_q);

    always @(posedge clk_i or negedge rst_ni) begin : grant_ctrl
        if (!rst_ni) begin
            wait_q  <= 2'd0;
            delay_q <= 2'd0;
            addr_q  <= '0;
        end else if (dcache_req_i.data_req && dcache_rsp_o.data_gnt) begin
            wait_q  <= 2'd0;
            delay_q <= $unsigned($random(seed)) % 3;
            // only a translated grant will be followed by a real tag
            if (dtlb_hit_o) begin
                addr_q <= vaddr_i;
            end
        end else if (dcache_req_i.data_req) begin
            wait_q <= wait_q + 2'd1;
        end
    end

endmodule

//--- tb/tb_load_unit.sv
// testbench top of the load unit
// stimulus tasks, reference formatting function, compare process and report

module tb_load_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import load_pkg::*;

    // about 90 loads of a few cycles each plus the short directed tests, with wide margin
    localparam int MAX_CYCLES = 2000;

    // one expected retirement, either a returned load or an early exception
    typedef struct packed {
        logic        is_ex;
        load_entry_t entry;
    } expect_t;

    logic                        clk, rst_n, flush, valid, tlb_block, page_offset_match;
    load_req_t                   load_req;
    exception_t                  ex, ex_out;
    logic [PLEN-1:0]             paddr;
    logic                        dtlb_hit, translation_req, pop_ld, ld_valid;
    logic [VLEN-1:0]             vaddr;
    logic [PAGE_OFFSET_BITS-1:0] page_offset;
    logic [TRANS_ID_BITS-1:0]    ld_trans_id;
    logic [XLEN-1:0]             ld_result;
    dcache_req_t                 dcache_req;
    dcache_rsp_t                 dcache_rsp;

    expect_t exp_q[$];
    string   test_name;
    integer  seed;
    int      errors, checks, cycles;

    tb_clkgen i_clkgen (.clk_o(clk), .rst_no(rst_n));

    tb_dcache_model i_dcache_model (
        .clk_i(clk), .rst_ni(rst_n), .tlb_block_i(tlb_block),
        .translation_req_i(translation_req), .vaddr_i(vaddr), .dtlb_hit_o(dtlb_hit),
        .paddr_o(paddr), .dcache_req_i(dcache_req), .dcache_rsp_o(dcache_rsp)
    );

    load_unit UUT (
        .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .valid_i(valid),
        .load_req_i(load_req), .pop_ld_o(pop_ld), .valid_o(ld_valid),
        .trans_id_o(ld_trans_id), .result_o(ld_result), .ex_o(ex_out),
        .translation_req_o(translation_req), .vaddr_o(vaddr), .paddr_i(paddr), .ex_i(ex),
        .dtlb_hit_i(dtlb_hit), .page_offset_o(page_offset),
        .page_offset_matches_i(page_offset_match), .dcache_req_o(dcache_req),
        .dcache_rsp_i(dcache_rsp)
    );

    // ------------------------------------------------------------------------
    // reference model and stimulus helpers
    // ------------------------------------------------------------------------
    // shift the addressed bytes down, then extend by operator
    function automatic logic [XLEN-1:0] ref_load(input logic [XLEN-1:0] rdata,
                                                 input logic [2:0] offset, input ld_op_e op);
        logic [XLEN-1:0] s;
        s = rdata >> (8 * offset);
        case (op)
            LW:      return {{32{s[31]}}, s[31:0]};
            LWU:     return {32'd0, s[31:0]};
            LH:      return {{48{s[15]}}, s[15:0]};
            LHU:     return {48'd0, s[15:0]};
            LB:      return {{56{s[7]}}, s[7:0]};
            LBU:     return {56'd0, s[7:0]};
            default: return s;
        endcase
    endfunction

    // the access has to stay inside one doubleword
    function automatic int max_offset(input ld_op_e op);
        case (op)
            LD:       return 0;
            LW, LWU:  return 4;
            LH, LHU:  return 6;
            default:  return 7;
        endcase
    endfunction

    // log2 of the number of bytes that the operator reads
    function automatic logic [1:0] access_size(input ld_op_e op);
        case (op)
            LD:       return 2'd3;
            LW, LWU:  return 2'd2;
            LH, LHU:  return 2'd1;
            default:  return 2'd0;
        endcase
    endfunction

    function automatic logic [VLEN-1:0] random_vaddr(input logic [2:0] offset);
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return {r[VLEN-1:3], offset};
    endfunction

    task automatic drive_load(input logic [VLEN-1:0] va, input ld_op_e op,
                              input logic [2:0] id);
        load_req = '{vaddr: va, trans_id: id, op: op, be: 8'hff};
        valid    = 1'b1;
    endtask

    // address and control fields that leave the unit in the cycle of the pop
    task automatic check_request();
        logic [PLEN-1:0]             pa;
        logic [TAG_WIDTH-1:0]        want_tag;
        logic [PAGE_OFFSET_BITS-1:0] want_off;
        pa       = {{(PLEN - VLEN){1'b0}}, load_req.vaddr};
        want_tag = pa[PLEN-1:PLEN-TAG_WIDTH];
        want_off = load_req.vaddr[PAGE_OFFSET_BITS-1:0];
        if (page_offset !== want_off) begin
            $display("FAIL %s page_offset expected %h actual %h", test_name, want_off,
                     page_offset);
            errors++;
        end
        if (dcache_req.address_index !== load_req.vaddr[INDEX_WIDTH-1:0]) begin
            $display("FAIL %s address_index expected %h actual %h", test_name,
                     load_req.vaddr[INDEX_WIDTH-1:0], dcache_req.address_index);
            errors++;
        end
        if (dcache_req.address_tag !== want_tag) begin
            $display("FAIL %s address_tag expected %h actual %h", test_name, want_tag,
                     dcache_req.address_tag);
            errors++;
        end
        if (dcache_req.data_size !== access_size(load_req.op)) begin
            $display("FAIL %s data_size expected %0d actual %0d", test_name,
                     access_size(load_req.op), dcache_req.data_size);
            errors++;
        end
        if (dcache_req.data_be !== load_req.be) begin
            $display("FAIL %s data_be expected %h actual %h", test_name, load_req.be,
                     dcache_req.data_be);
            errors++;
        end
    endtask

    // waits for the pop of the driven load and records its expected retirement
    task automatic complete_load();
        expect_t e;
        logic    popped;
        popped = 1'b0;
        while (!popped) begin
            @(negedge clk);
            popped = pop_ld;
            if (popped) begin
                check_request();
            end
            @(posedge clk);
            #1;
        end
        valid   = 1'b0;
        e.is_ex = 1'b0;
        e.entry = '{trans_id: load_req.trans_id, offset: load_req.vaddr[2:0], op: load_req.op};
        exp_q.push_back(e);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input int err_start);
        if (errors == err_start) $display("%s: passed", test_name);
        else $display("%s: %0d errors", test_name, errors - err_start);
    endtask

    // ------------------------------------------------------------------------
    // compare process, outputs are stable at the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : compare
        expect_t         e;
        logic [XLEN-1:0] want;
        if (rst_n && ld_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR %s: valid_o raised with no load outstanding", test_name);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checks++;
                if (ld_trans_id != e.entry.trans_id) begin
                    $display("FAIL %s trans_id expected %0d actual %0d", test_name,
                             e.entry.trans_id, ld_trans_id);
                    errors++;
                end
                if (e.is_ex) begin
                    if (ex_out !== ex) begin
                        $display("FAIL %s ex_o expected %h actual %h", test_name, ex, ex_out);
                        errors++;
                    end
                end else begin
                    want = ref_load(dcache_rsp.data_rdata, e.entry.offset, e.entry.op);
                    if (ld_result !== want) begin
                        $display("FAIL %s result expected %h actual %h", test_name, want,
                                 ld_result);
                        errors++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int         err_start;
        ld_op_e     op;
        logic [2:0] id;
        expect_t    e;
        seed = 4;
        errors = 0;
        checks = 0;
        cycles = 0;
        id = 3'd0;
        flush = 1'b0;
        valid = 1'b0;
        tlb_block = 1'b0;
        page_offset_match = 1'b0;
        load_req = '0;
        ex = '0;
        @(posedge rst_n);
        @(posedge clk);
        #1;

        // every operator at every offset that stays in the doubleword
        test_name = "formatting";
        err_start = errors;
        for (int o = 0; o < 7; o++) begin
            op = ld_op_e'(o);
            for (int off = 0; off <= max_offset(op); off++) begin
                drive_load(random_vaddr(off), op, id);
                complete_load();
                id++;
            end
        end
        drain();
        report_test(err_start);

        // each new load is offered in the tag cycle of the one before
        test_name = "back_to_back";
        err_start = errors;
        for (int n = 0; n < 40; n++) begin
            op = ld_op_e'($unsigned($random(seed)) % 7);
            drive_load(random_vaddr($unsigned($random(seed)) % (max_offset(op) + 1)), op, id);
            complete_load();
            id++;
        end
        drain();
        report_test(err_start);

        // the abort has to show as a killed tag before translation is retried
        test_name = "tlb_miss";
        err_start = errors;
        tlb_block = 1'b1;
        drive_load(random_vaddr(3'd3), LW, id);
        do @(negedge clk); while (!dcache_req.tag_valid);
        if (!dcache_req.kill_req) begin
            $display("ERROR %s: tag sent without kill after the TLB miss", test_name);
            errors++;
        end
        repeat (4) begin
            @(negedge clk);
            if (!translation_req) begin
                $display("ERROR %s: translation request dropped before the hit", test_name);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        tlb_block = 1'b0;
        complete_load();
        id++;
        drain();
        report_test(err_start);

        // the match is registered, so it is raised one cycle ahead of the load
        test_name = "page_offset";
        err_start = errors;
        page_offset_match = 1'b1;
        @(posedge clk);
        #1;
        drive_load(random_vaddr(3'd6), LHU, id);
        repeat (4) begin
            @(negedge clk);
            if (dcache_req.data_req || pop_ld) begin
                $display("ERROR %s: cache request sent during a page offset match", test_name);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        page_offset_match = 1'b0;
        complete_load();
        id++;
        drain();
        report_test(err_start);

        // an excepting load retires in its own request cycle
        test_name = "exception";
        err_start = errors;
        e.is_ex = 1'b1;
        e.entry = '{trans_id: id, offset: 3'd0, op: LD};
        exp_q.push_back(e);
        ex = '{valid: 1'b1, cause: 64'd5, tval: {25'd0, random_vaddr(3'd0)}};
        drive_load(ex.tval[VLEN-1:0], LD, id);
        @(negedge clk);
        if (!ld_valid || !pop_ld) begin
            $display("ERROR %s: exception did not retire in its request cycle", test_name);
            errors++;
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
        ex = '0;
        id++;
        drain();
        report_test(err_start);

        // flush kills in the next cycle, then a load must still complete
        test_name = "flush";
        err_start = errors;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        if (!(dcache_req.kill_req && dcache_req.tag_valid) || ld_valid) begin
            $display("ERROR %s: no clean kill in the cycle after the flush", test_name);
            errors++;
        end
        @(posedge clk);
        #1;
        drive_load(random_vaddr(3'd7), LB, id);
        complete_load();
        drain();
        report_test(err_start);

        $display("results: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- files.f
hw/load_pkg.sv
hw/load_fsm.sv
hw/load_result_align.sv
hw/load_unit.sv
tb/tb_clkgen.sv
tb/tb_dcache_model.sv
tb/tb_load_unit.sv
